//--- Bender.yml
package:
  name: decode_stage

sources:
  - verilog/decode_pkg.sv
  - verilog/instr_decoder.sv
  - verilog/reg_file.sv
  - verilog/scoreboard.sv
  - verilog/rob_ticket_counter.sv
  - verilog/dispatch_fsm.sv
  - verilog/issue_reg.sv
  - verilog/decode_top.sv
  - target: test
    files:
      - test/decode_assert.sv
      - test/decode_tb.sv

//--- test/decode_assert.sv
`timescale 1ns/10ps

module decode_assert
(
    input logic clock,
    input logic rst,
    input logic fetch_valid,
    input logic flush_decode,
    input logic stall_fetch,
    input logic alu_valid,
    input logic mul_valid
);

// One execution port at a time
onehot_port: assert property (@(posedge clock) disable iff (rst)
    !(alu_valid && mul_valid))
    else $error("ALU and MUL valid high together");

flush_kills_valid: assert property (@(posedge clock) disable iff (rst)
    flush_decode |=> (!alu_valid && !mul_valid))
    else $error("Output valid high in the cycle after a flush");

reset_clears_stall: assert property (@(posedge clock)
    rst |=> !stall_fetch)
    else $error("stall_fetch high in the cycle after reset");

// Fetch honours the stall
no_fetch_when_stalled: assert property (@(posedge clock) disable iff (rst)
    !(fetch_valid && stall_fetch))
    else $error("fetch_valid high while stall_fetch is high");

endmodule

bind decode_top decode_assert assert0
(
    .clock        (clock),
    .rst          (rst),
    .fetch_valid  (fetch_valid),
    .flush_decode (flush_decode),
    .stall_fetch  (stall_fetch),
    .alu_valid    (alu_valid),
    .mul_valid    (mul_valid)
);

//--- test/decode_tb.sv
`timescale 1ns/10ps

module decode_tb
    import decode_pkg::*;
();

localparam int ROB_ENTRIES = 8;

// Expected valids in a row refer to the cycle after it
typedef struct packed
{
    logic                      fv;
    logic [INSTR_WIDTH-1:0]    instr;
    logic                      stall;
    logic                      flush;
    logic                      wbv;
    logic [REG_ADDR_WIDTH-1:0] wb_addr;
    logic [TICKET_WIDTH-1:0]   wb_rob;
    logic                      exp_alu;
    logic                      exp_mul;
} stim_row_t;

logic                   clock;
logic                   rst;
logic                   fetch_valid;
logic [INSTR_WIDTH-1:0] fetch_instr;
logic [PC_WIDTH-1:0]    fetch_pc;
logic                   stall_decode;
logic                   flush_decode;
logic                   wb_valid;
writeback_t             wb;
logic                   stall_fetch;
logic                   alu_valid;
exec_request_t          alu_req;
logic                   mul_valid;
exec_request_t          mul_req;

stim_row_t              stim[$];
integer                 seed;
int                     cycles;

// Reference model state
logic [DATA_WIDTH-1:0]   m_regs [NUM_REGS];
logic                    m_blk [NUM_REGS];
logic [TICKET_WIDTH-1:0] m_own [NUM_REGS];
logic [TICKET_WIDTH-1:0] m_ticket;
dispatch_state_e         m_state;
exec_request_t           m_req;
logic                    exp_sf;
logic                    exp_alu;
logic                    exp_mul;

decode_top #(
    .ROB_ENTRIES (ROB_ENTRIES)
) dut0
(
    .clock        (clock),
    .rst          (rst),
    .fetch_valid  (fetch_valid),
    .fetch_instr  (fetch_instr),
    .fetch_pc     (fetch_pc),
    .stall_fetch  (stall_fetch),
    .stall_decode (stall_decode),
    .flush_decode (flush_decode),
    .wb_valid     (wb_valid),
    .wb           (wb),
    .alu_valid    (alu_valid),
    .alu_req      (alu_req),
    .mul_valid    (mul_valid),
    .mul_req      (mul_req)
);

initial
    clock = 1'b0;

always #20 clock = ~clock;

// Run length bound
always @(posedge clock)
begin
    cycles = cycles + 1;
    if (cycles > stim.size() * 4 + 64)
    begin
        $display("Timeout: run did not finish after %0d cycles", cycles);
        $display("TESTS FAILED");
        $fatal(1, "Simulation ran past its cycle limit");
    end
end

//////////////////////////////////////////////////
// Helpers
//////////////////////////////////////////////////

task automatic check_value(input string name, input logic [63:0] actual,
                           input logic [63:0] expected);
    if (actual !== expected)
    begin
        $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, actual, expected);
        $display("TESTS FAILED");
        $fatal(1, "Mismatch on %s", name);
    end
endtask

function automatic logic [INSTR_WIDTH-1:0] make_instr(input logic [6:0] op, input int rd,
                                                      input int ra, input int low);
    logic [REG_ADDR_WIDTH-1:0] rd_f;
    logic [REG_ADDR_WIDTH-1:0] ra_f;
    logic [OFFSET_WIDTH-1:0]   low_f;
    rd_f  = rd[REG_ADDR_WIDTH-1:0];
    ra_f  = ra[REG_ADDR_WIDTH-1:0];
    low_f = low[OFFSET_WIDTH-1:0];
    return {op, rd_f, ra_f, low_f};
endfunction

task automatic add_row(input logic fv, input logic [INSTR_WIDTH-1:0] instr, input logic stall,
                       input logic flush, input logic wbv, input int wb_addr, input int wb_rob,
                       input logic alu, input logic mul);
    stim_row_t r;
    r.fv      = fv;
    r.instr   = instr;
    r.stall   = stall;
    r.flush   = flush;
    r.wbv     = wbv;
    r.wb_addr = wb_addr[REG_ADDR_WIDTH-1:0];
    r.wb_rob  = wb_rob[TICKET_WIDTH-1:0];
    r.exp_alu = alu;
    r.exp_mul = mul;
    stim.push_back(r);
endtask

// Operand as the model sees it before the clock edge
function automatic src_operand_t read_operand(input logic [REG_ADDR_WIDTH-1:0] a,
                                              input logic used, input stim_row_t r,
                                              input logic [DATA_WIDTH-1:0] wdata);
    logic         hit;
    src_operand_t o;
    hit       = r.wbv && (r.wb_addr == a);
    o.data    = hit ? wdata : m_regs[a];
    o.blocked = used && m_blk[a] && !(hit && m_own[a] == r.wb_rob);
    o.ticket  = m_own[a];
    return o;
endfunction

//////////////////////////////////////////////////
// Reference model stepped once per clock edge
//////////////////////////////////////////////////

task automatic model_cycle(input stim_row_t r, input logic [DATA_WIDTH-1:0] wdata,
                           input logic [PC_WIDTH-1:0] pc);
    logic [6:0]                op;
    logic [REG_ADDR_WIDTH-1:0] rd;
    logic [REG_ADDR_WIDTH-1:0] s2;
    logic                      legal;
    logic                      u1;
    logic                      u2;
    logic                      wr;
    logic                      accept;
    exec_request_t             nr;
    op     = r.instr[31:25];
    rd     = r.instr[24:20];
    s2     = (op == STW) ? rd : r.instr[14:10];
    legal  = op inside {ADD, SUB, MUL, ADDI, LDW, STW, BEQ, JUMP, NOP};
    u1     = op inside {ADD, SUB, MUL, ADDI, LDW, STW, BEQ};
    u2     = op inside {ADD, SUB, MUL, STW, BEQ};
    wr     = op inside {ADD, SUB, MUL, ADDI, LDW};
    accept = r.fv && (m_state == IDLE) && !r.flush;

    nr               = '0;
    nr.opcode        = opcode_e'(op);
    nr.rd_addr       = rd;
    nr.src1          = read_operand(r.instr[19:15], u1, r, wdata);
    nr.src2          = read_operand(s2, u2, r, wdata);
    nr.offset        = {{(DATA_WIDTH - OFFSET_WIDTH){1'b0}}, r.instr[14:0]};
    nr.pc            = pc;
    nr.instr_id      = m_ticket;
    nr.illegal_instr = !legal;
    if (accept)
    begin
        m_req = nr;
    end

    if (r.flush)
        m_state = IDLE;
    else if (m_state == IDLE && accept && r.stall)
        m_state = HELD;
    else if (m_state == HELD && !r.stall)
        m_state = IDLE;
    exp_sf = (m_state == HELD);

    // A new owner on the same register wins over the clear
    if (r.wbv && m_own[r.wb_addr] == r.wb_rob)
        m_blk[r.wb_addr] = 1'b0;
    if (accept && wr)
    begin
        m_blk[rd] = 1'b1;
        m_own[rd] = m_ticket;
    end
    if (r.wbv)
        m_regs[r.wb_addr] = wdata;
    if (accept)
        m_ticket = (m_ticket == ROB_ENTRIES - 1) ? '0 : m_ticket + 1'b1;
endtask

task automatic check_request(input string name, input exec_request_t got);
    check_value({name, ".opcode"}, got.opcode, m_req.opcode);
    check_value({name, ".rd_addr"}, got.rd_addr, m_req.rd_addr);
    check_value({name, ".src1.data"}, got.src1.data, m_req.src1.data);
    check_value({name, ".src1.blocked"}, got.src1.blocked, m_req.src1.blocked);
    check_value({name, ".src1.ticket"}, got.src1.ticket, m_req.src1.ticket);
    check_value({name, ".src2.data"}, got.src2.data, m_req.src2.data);
    check_value({name, ".src2.blocked"}, got.src2.blocked, m_req.src2.blocked);
    check_value({name, ".src2.ticket"}, got.src2.ticket, m_req.src2.ticket);
    check_value({name, ".offset"}, got.offset, m_req.offset);
    check_value({name, ".pc"}, got.pc, m_req.pc);
    check_value({name, ".instr_id"}, got.instr_id, m_req.instr_id);
    check_value({name, ".illegal_instr"}, got.illegal_instr, m_req.illegal_instr);
endtask

task automatic check_outputs();
    check_value("stall_fetch", stall_fetch, exp_sf);
    check_value("alu_valid", alu_valid, exp_alu);
    check_value("mul_valid", mul_valid, exp_mul);
    if (exp_alu)
        check_request("alu_req", alu_req);
    if (exp_mul)
        check_request("mul_req", mul_req);
endtask

//////////////////////////////////////////////////
// Stimulus table
//////////////////////////////////////////////////

task automatic build_table();
    // Fill r1..r4
    add_row(0, '0, 0, 0, 1, 1, 0, 0, 0);
    add_row(0, '0, 0, 0, 1, 2, 0, 0, 0);
    add_row(0, '0, 0, 0, 1, 3, 0, 0, 0);
    add_row(0, '0, 0, 0, 1, 4, 0, 0, 0);
    // Routing with tickets 0 to 3
    add_row(1, make_instr(ADD, 5, 1, 2 << 10), 0, 0, 0, 0, 0, 1, 0);
    add_row(1, make_instr(ADDI, 6, 3, 'h1234), 0, 0, 0, 0, 0, 1, 0);
    add_row(1, make_instr(LDW, 7, 4, 'h7fff), 0, 0, 0, 0, 0, 1, 0);
    add_row(1, make_instr(MUL, 8, 5, 6 << 10), 0, 0, 0, 0, 0, 0, 1);
    // Bypass of r4 and same-cycle release of r5
    add_row(1, make_instr(ADD, 9, 1, 4 << 10), 0, 0, 1, 4, 5, 1, 0);
    add_row(1, make_instr(ADD, 10, 5, 7 << 10), 0, 0, 1, 5, 0, 1, 0);
    // Wrong rob_id keeps r7 blocked and the store reads rd as src2
    add_row(1, make_instr(STW, 7, 5, 0), 0, 0, 1, 7, 3, 1, 0);
    add_row(0, '0, 0, 0, 1, 7, 2, 0, 0);
    add_row(1, make_instr(STW, 7, 6, 'h0040), 0, 0, 0, 0, 0, 1, 0);
    add_row(1, make_instr(SUB, 11, 2, 3 << 10), 0, 0, 0, 0, 0, 1, 0);
    // Hold under stall then release
    add_row(1, make_instr(MUL, 12, 9, 10 << 10), 1, 0, 0, 0, 0, 0, 0);
    add_row(0, '0, 1, 0, 0, 0, 0, 0, 0);
    add_row(0, '0, 0, 0, 0, 0, 0, 0, 1);
    add_row(0, '0, 0, 0, 0, 0, 0, 0, 0);
    // Held instruction dropped by flush
    add_row(1, make_instr(ADD, 13, 1, 2 << 10), 1, 0, 0, 0, 0, 0, 0);
    add_row(0, '0, 1, 1, 0, 0, 0, 0, 0);
    add_row(0, '0, 0, 0, 0, 0, 0, 0, 0);
    add_row(1, make_instr(ADD, 14, 1, 2 << 10), 0, 1, 0, 0, 0, 0, 0);
    add_row(1, make_instr(ADD, 15, 13, 14 << 10), 0, 0, 0, 0, 0, 1, 0);
    // Illegal opcode leaves r16 free
    add_row(1, make_instr(7'h55, 16, 1, 2 << 10), 0, 0, 0, 0, 0, 1, 0);
    add_row(1, make_instr(ADD, 17, 16, 16 << 10), 0, 0, 0, 0, 0, 1, 0);
    add_row(1, make_instr(JUMP, 0, 0, 'h4321), 0, 0, 0, 0, 0, 1, 0);
    add_row(1, make_instr(NOP, 0, 0, 0), 0, 0, 0, 0, 0, 1, 0);
    add_row(1, make_instr(BEQ, 0, 1, 2 << 10), 0, 0, 0, 0, 0, 1, 0);
    add_row(0, '0, 0, 0, 0, 0, 0, 0, 0);
endtask

initial
begin
    logic [DATA_WIDTH-1:0] wdata;
    logic [PC_WIDTH-1:0]   pc;
    seed         = 69;
    cycles       = 0;
    rst          = 1'b1;
    fetch_valid  = 1'b0;
    fetch_instr  = '0;
    fetch_pc     = '0;
    stall_decode = 1'b0;
    flush_decode = 1'b0;
    wb_valid     = 1'b0;
    wb           = '0;
    for (int i = 0; i < NUM_REGS; i++)
    begin
        m_regs[i] = '0;
        m_blk[i]  = 1'b0;
        m_own[i]  = '0;
    end
    m_ticket = '0;
    m_state  = IDLE;
    m_req    = '0;
    exp_sf   = 1'b0;
    exp_alu  = 1'b0;
    exp_mul  = 1'b0;
    build_table();

    repeat (16) @(posedge clock);
    #2 rst = 1'b0;

    foreach (stim[i])
    begin
        @(posedge clock);
        #1 check_outputs();
        #1;
        wdata        = $random(seed);
        pc           = 32'h0000_1000 + i * 4;
        fetch_valid  = stim[i].fv;
        fetch_instr  = stim[i].instr;
        fetch_pc     = pc;
        stall_decode = stim[i].stall;
        flush_decode = stim[i].flush;
        wb_valid     = stim[i].wbv;
        wb.reg_addr  = stim[i].wb_addr;
        wb.data      = wdata;
        wb.rob_id    = stim[i].wb_rob;
        exp_alu      = stim[i].exp_alu;
        exp_mul      = stim[i].exp_mul;
        model_cycle(stim[i], wdata, pc);
    end
    @(posedge clock);
    #1 check_outputs();

    $display("TESTS PASSED");
    $finish;
end

endmodule

//--- verilog/decode_pkg.sv
package decode_pkg;

    //////////////////////////////////////////////////
    // Widths
    //////////////////////////////////////////////////

    localparam int INSTR_WIDTH    = 32;
    localparam int DATA_WIDTH     = 32;
    localparam int REG_ADDR_WIDTH = 5;
    localparam int NUM_REGS       = 1 << REG_ADDR_WIDTH;
    localparam int OFFSET_WIDTH   = 15;
    localparam int TICKET_WIDTH   = 4;
    localparam int PC_WIDTH       = 32;

    // Instruction field positions
    localparam int OPCODE_HI = 31;
    localparam int OPCODE_LO = 25;
    localparam int RD_HI     = 24;
    localparam int RD_LO     = 20;
    localparam int RA_HI     = 19;
    localparam int RA_LO     = 15;
    localparam int RB_HI     = 14;
    localparam int RB_LO     = 10;
    localparam int OFFSET_HI = OFFSET_WIDTH - 1;
    localparam int OFFSET_LO = 0;

    //////////////////////////////////////////////////
    // Encodings
    //////////////////////////////////////////////////

    typedef enum logic [6:0]
    {
        ADD  = 7'h00,
        SUB  = 7'h01,
        MUL  = 7'h02,
        ADDI = 7'h03,
        LDW  = 7'h10,
        STW  = 7'h11,
        BEQ  = 7'h30,
        JUMP = 7'h31,
        NOP  = 7'h7f
    } opcode_e;

    typedef enum logic [0:0]
    {
        IDLE = 1'b0,
        HELD = 1'b1
    } dispatch_state_e;

    //////////////////////////////////////////////////
    // Bundles
    //////////////////////////////////////////////////

    typedef struct packed
    {
        logic [DATA_WIDTH-1:0]   data;
        logic                    blocked;
        logic [TICKET_WIDTH-1:0] ticket;
    } src_operand_t;

    typedef struct packed
    {
        opcode_e                   opcode;
        logic [REG_ADDR_WIDTH-1:0] rd_addr;
        src_operand_t              src1;
        src_operand_t              src2;
        logic [DATA_WIDTH-1:0]     offset;
        logic [PC_WIDTH-1:0]       pc;
        logic [TICKET_WIDTH-1:0]   instr_id;
        logic                      illegal_instr;
    } exec_request_t;

    typedef struct packed
    {
        logic [REG_ADDR_WIDTH-1:0] reg_addr;
        logic [DATA_WIDTH-1:0]     data;
        logic [TICKET_WIDTH-1:0]   rob_id;
    } writeback_t;

endpackage

//--- verilog/decode_top.sv
`timescale 1ns/10ps

module decode_top
    import decode_pkg::*;
#(
    parameter int ROB_ENTRIES = 8
)
(
    input  logic                   clock,
    input  logic                   rst,

    // Fetch side
    input  logic                   fetch_valid,
    input  logic [INSTR_WIDTH-1:0] fetch_instr,
    input  logic [PC_WIDTH-1:0]    fetch_pc,
    output logic                   stall_fetch,

    // Pipeline control
    input  logic                   stall_decode,
    input  logic                   flush_decode,

    // Register write-back
    input  logic                   wb_valid,
    input  writeback_t             wb,

    // Execution ports
    output logic                   alu_valid,
    output exec_request_t          alu_req,
    output logic                   mul_valid,
    output exec_request_t          mul_req
);

logic [REG_ADDR_WIDTH-1:0] src1_addr;
logic [REG_ADDR_WIDTH-1:0] src2_addr;
logic [REG_ADDR_WIDTH-1:0] rd_addr;
logic [DATA_WIDTH-1:0]     rd_data1;
logic [DATA_WIDTH-1:0]     rd_data2;
logic                      src1_blocked;
logic                      src2_blocked;
logic [TICKET_WIDTH-1:0]   src1_ticket;
logic [TICKET_WIDTH-1:0]   src2_ticket;
logic                      writes_rd;
logic                      is_mul;
exec_request_t             request;
logic [TICKET_WIDTH-1:0]   ticket;
logic                      accept;
logic                      load;
logic                      issue;

//////////////////////////////////////////////////
// Field split and operand gathering
//////////////////////////////////////////////////

instr_decoder decoder0
(
    .fetch_instr  (fetch_instr),
    .fetch_pc     (fetch_pc),
    .rd_data1     (rd_data1),
    .rd_data2     (rd_data2),
    .src1_blocked (src1_blocked),
    .src1_ticket  (src1_ticket),
    .src2_blocked (src2_blocked),
    .src2_ticket  (src2_ticket),
    .src1_addr    (src1_addr),
    .src2_addr    (src2_addr),
    .rd_addr      (rd_addr),
    .uses_src1    (),
    .uses_src2    (),
    .writes_rd    (writes_rd),
    .is_mul       (is_mul),
    .request      (request)
);

reg_file regs0
(
    .clock     (clock),
    .rst       (rst),
    .src1_addr (src1_addr),
    .src2_addr (src2_addr),
    .wb_valid  (wb_valid),
    .wb        (wb),
    .rd_data1  (rd_data1),
    .rd_data2  (rd_data2)
);

scoreboard #(
    .ROB_ENTRIES (ROB_ENTRIES)
) sb0
(
    .clock        (clock),
    .rst          (rst),
    .flush_decode (flush_decode),
    .accept       (accept),
    .writes_rd    (writes_rd),
    .rd_addr      (rd_addr),
    .ticket       (ticket),
    .src1_addr    (src1_addr),
    .src2_addr    (src2_addr),
    .wb_valid     (wb_valid),
    .wb           (wb),
    .src1_blocked (src1_blocked),
    .src1_ticket  (src1_ticket),
    .src2_blocked (src2_blocked),
    .src2_ticket  (src2_ticket)
);

//////////////////////////////////////////////////
// Ticketing and dispatch
//////////////////////////////////////////////////

rob_ticket_counter #(
    .ROB_ENTRIES (ROB_ENTRIES)
) tickets0
(
    .clock  (clock),
    .rst    (rst),
    .accept (accept),
    .ticket (ticket)
);

dispatch_fsm fsm0
(
    .clock        (clock),
    .rst          (rst),
    .fetch_valid  (fetch_valid),
    .stall_decode (stall_decode),
    .flush_decode (flush_decode),
    .accept       (accept),
    .load         (load),
    .issue        (issue),
    .stall_fetch  (stall_fetch)
);

issue_reg issue0
(
    .clock        (clock),
    .rst          (rst),
    .load         (load),
    .issue        (issue),
    .flush_decode (flush_decode),
    .is_mul       (is_mul),
    .request      (request),
    .ticket       (ticket),
    .alu_valid    (alu_valid),
    .alu_req      (alu_req),
    .mul_valid    (mul_valid),
    .mul_req      (mul_req)
);

endmodule

//--- verilog/dispatch_fsm.sv
`timescale 1ns/10ps

module dispatch_fsm
    import decode_pkg::*;
(
    input  logic clock,
    input  logic rst,

    input  logic fetch_valid,
    input  logic stall_decode,
    input  logic flush_decode,

    output logic accept,
    output logic load,
    output logic issue,
    output logic stall_fetch
);

dispatch_state_e state;
dispatch_state_e state_next;

// New instruction only when nothing is held and no flush
assign accept = fetch_valid && (state == IDLE) && !flush_decode;
assign load   = accept;

assign issue = (accept && !stall_decode)
             || ((state == HELD) && !stall_decode && !flush_decode);

assign stall_fetch = (state == HELD);

always_comb
begin
    state_next = state;
    if (flush_decode)
        state_next = IDLE;
    else
    begin
        case (state)
            IDLE:
            begin
                if (accept && stall_decode)
                    state_next = HELD;
            end
            HELD:
            begin
                if (!stall_decode)
                    state_next = IDLE;
            end
            default:
            begin
                state_next = IDLE;
            end
        endcase
    end
end

always_ff @(posedge clock)
begin
    if (rst)
        state <= IDLE;
    else
        state <= state_next;
end

endmodule

//--- verilog/instr_decoder.sv
`timescale 1ns/10ps

module instr_decoder
    import decode_pkg::*;
(
    input  logic [INSTR_WIDTH-1:0]    fetch_instr,
    input  logic [PC_WIDTH-1:0]       fetch_pc,

    // Operand data and scoreboard status
    input  logic [DATA_WIDTH-1:0]     rd_data1,
    input  logic [DATA_WIDTH-1:0]     rd_data2,
    input  logic                      src1_blocked,
    input  logic [TICKET_WIDTH-1:0]   src1_ticket,
    input  logic                      src2_blocked,
    input  logic [TICKET_WIDTH-1:0]   src2_ticket,

    output logic [REG_ADDR_WIDTH-1:0] src1_addr,
    output logic [REG_ADDR_WIDTH-1:0] src2_addr,
    output logic [REG_ADDR_WIDTH-1:0] rd_addr,
    output logic                      uses_src1,
    output logic                      uses_src2,
    output logic                      writes_rd,
    output logic                      is_mul,
    output exec_request_t             request
);

opcode_e opcode;
logic    illegal;

assign opcode  = opcode_e'(fetch_instr[OPCODE_HI:OPCODE_LO]);
assign rd_addr = fetch_instr[RD_HI:RD_LO];
assign is_mul  = (opcode == MUL);

// Stores read their data register through the second port
assign src1_addr = fetch_instr[RA_HI:RA_LO];
assign src2_addr = (opcode == STW) ? rd_addr : fetch_instr[RB_HI:RB_LO];

// Operand usage per opcode
always_comb
begin
    uses_src1 = 1'b0;
    uses_src2 = 1'b0;
    writes_rd = 1'b0;
    illegal   = 1'b0;
    case (opcode)
        ADD, SUB, MUL:
        begin
            uses_src1 = 1'b1;
            uses_src2 = 1'b1;
            writes_rd = 1'b1;
        end
        ADDI, LDW:
        begin
            uses_src1 = 1'b1;
            writes_rd = 1'b1;
        end
        STW, BEQ:
        begin
            uses_src1 = 1'b1;
            uses_src2 = 1'b1;
        end
        JUMP, NOP:
        begin
            // No register operands
            uses_src1 = 1'b0;
        end
        default:
        begin
            illegal = 1'b1;
        end
    endcase
end

// Ticket is filled in by the issue register
always_comb
begin
    request               = '0;
    request.opcode        = opcode;
    request.rd_addr       = rd_addr;
    request.src1.data     = rd_data1;
    request.src1.blocked  = uses_src1 & src1_blocked;
    request.src1.ticket   = src1_ticket;
    request.src2.data     = rd_data2;
    request.src2.blocked  = uses_src2 & src2_blocked;
    request.src2.ticket   = src2_ticket;
    request.offset        = DATA_WIDTH'(fetch_instr[OFFSET_HI:OFFSET_LO]);
    request.pc            = fetch_pc;
    request.illegal_instr = illegal;
end

endmodule

//--- verilog/issue_reg.sv
`timescale 1ns/10ps

module issue_reg
    import decode_pkg::*;
(
    input  logic                    clock,
    input  logic                    rst,

    input  logic                    load,
    input  logic                    issue,
    input  logic                    flush_decode,
    input  logic                    is_mul,
    input  exec_request_t           request,
    input  logic [TICKET_WIDTH-1:0] ticket,

    output logic                    alu_valid,
    output exec_request_t           alu_req,
    output logic                    mul_valid,
    output exec_request_t           mul_req
);

exec_request_t req_q;
logic          mul_q;
logic          to_mul;

// Unit of a request issued in its own accept cycle comes from the decoder
assign to_mul = load ? is_mul : mul_q;

always_ff @(posedge clock)
begin
    if (load)
    begin
        req_q          <= request;
        req_q.instr_id <= ticket;
        mul_q          <= is_mul;
    end
end

always_ff @(posedge clock)
begin
    if (rst || flush_decode)
    begin
        alu_valid <= 1'b0;
        mul_valid <= 1'b0;
    end
    else
    begin
        alu_valid <= issue && !to_mul;
        mul_valid <= issue && to_mul;
    end
end

assign alu_req = req_q;
assign mul_req = req_q;

endmodule

//--- verilog/reg_file.sv
`timescale 1ns/10ps

module reg_file
    import decode_pkg::*;
(
    input  logic                      clock,
    input  logic                      rst,

    input  logic [REG_ADDR_WIDTH-1:0] src1_addr,
    input  logic [REG_ADDR_WIDTH-1:0] src2_addr,

    input  logic                      wb_valid,
    input  writeback_t                wb,

    output logic [DATA_WIDTH-1:0]     rd_data1,
    output logic [DATA_WIDTH-1:0]     rd_data2
);

logic [DATA_WIDTH-1:0] regs [NUM_REGS];

always_ff @(posedge clock)
begin
    if (rst)
    begin
        for (int i = 0; i < NUM_REGS; i++)
            regs[i] <= '0;
    end
    else if (wb_valid)
    begin
        regs[wb.reg_addr] <= wb.data;
    end
end

// A write-back in flight overrides the stored value
assign rd_data1 = (wb_valid && wb.reg_addr == src1_addr) ? wb.data : regs[src1_addr];
assign rd_data2 = (wb_valid && wb.reg_addr == src2_addr) ? wb.data : regs[src2_addr];

endmodule

//--- verilog/rob_ticket_counter.sv
`timescale 1ns/10ps

module rob_ticket_counter
    import decode_pkg::*;
#(
    parameter int ROB_ENTRIES = 8
)
(
    input  logic                    clock,
    input  logic                    rst,
    input  logic                    accept,
    output logic [TICKET_WIDTH-1:0] ticket
);

localparam logic [TICKET_WIDTH-1:0] LAST = TICKET_WIDTH'(ROB_ENTRIES - 1);

// Current value is the ticket of the instruction being accepted
always_ff @(posedge clock)
begin
    if (rst)
        ticket <= '0;
    else if (accept)
    begin
        if (ticket == LAST)
            ticket <= '0;
        else
            ticket <= ticket + 1'b1;
    end
end

endmodule

//--- verilog/scoreboard.sv
`timescale 1ns/10ps

module scoreboard
    import decode_pkg::*;
#(
    parameter int ROB_ENTRIES = 8
)
(
    input  logic                      clock,
    input  logic                      rst,
    input  logic                      flush_decode,

    // Dispatch side
    input  logic                      accept,
    input  logic                      writes_rd,
    input  logic [REG_ADDR_WIDTH-1:0] rd_addr,
    input  logic [TICKET_WIDTH-1:0]   ticket,

    // Source lookups
    input  logic [REG_ADDR_WIDTH-1:0] src1_addr,
    input  logic [REG_ADDR_WIDTH-1:0] src2_addr,

    input  logic                      wb_valid,
    input  writeback_t                wb,

    output logic                      src1_blocked,
    output logic [TICKET_WIDTH-1:0]   src1_ticket,
    output logic                      src2_blocked,
    output logic [TICKET_WIDTH-1:0]   src2_ticket
);

// Tickets never reach ROB_ENTRIES so fewer bits are stored
localparam int ID_W = (ROB_ENTRIES > 1) ? $clog2(ROB_ENTRIES) : 1;

logic [NUM_REGS-1:0] blocked;
logic [ID_W-1:0]     owner [NUM_REGS];
logic                wb_hit;
logic                src1_wb_match;
logic                src2_wb_match;

assign wb_hit = wb_valid && (TICKET_WIDTH'(owner[wb.reg_addr]) == wb.rob_id);

////////////////////////////////////////////////////
// Lookups with same-cycle release

assign src1_ticket   = TICKET_WIDTH'(owner[src1_addr]);
assign src2_ticket   = TICKET_WIDTH'(owner[src2_addr]);
assign src1_wb_match = wb_hit && (wb.reg_addr == src1_addr);
assign src2_wb_match = wb_hit && (wb.reg_addr == src2_addr);
assign src1_blocked  = blocked[src1_addr] && !src1_wb_match;
assign src2_blocked  = blocked[src2_addr] && !src2_wb_match;

////////////////////////////////////////////////////
// Flag update, set after clear so it wins

always_ff @(posedge clock)
begin
    if (rst)
    begin
        blocked <= '0;
        for (int i = 0; i < NUM_REGS; i++)
            owner[i] <= '0;
    end
    else
    begin
        if (wb_hit)
            blocked[wb.reg_addr] <= 1'b0;
        if (accept && writes_rd && !flush_decode)
        begin
            blocked[rd_addr] <= 1'b1;
            owner[rd_addr]   <= ticket[ID_W-1:0];
        end
    end
end

endmodule

//--- vlog.f
verilog/decode_pkg.sv
verilog/instr_decoder.sv
verilog/reg_file.sv
verilog/scoreboard.sv
verilog/rob_ticket_counter.sv
verilog/dispatch_fsm.sv
verilog/issue_reg.sv
verilog/decode_top.sv
test/decode_assert.sv
test/decode_tb.sv
